//--- hw/icache_pkg.sv
package icache_pkg;

    // address split into tag, index and byte offset
    localparam int TAG_WIDTH      = 20;
    localparam int INDEX_WIDTH    = 8;
    localparam int OFFSET_WIDTH   = 4;

    localparam int LINE_NUM       = 1 << INDEX_WIDTH;
    localparam int WORDS_PER_LINE = (1 << OFFSET_WIDTH) / 4;
    localparam int LINE_WIDTH     = WORDS_PER_LINE * 32;

    typedef logic [TAG_WIDTH-1:0]                  tag_t;
    typedef logic [INDEX_WIDTH-1:0]                index_t;
    typedef logic [OFFSET_WIDTH-1:0]               offset_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]     word_idx_t;
    typedef logic [31:0]                           word_t;
    typedef logic [LINE_WIDTH-1:0]                 line_t;
    typedef logic [31:0]                           addr_t;

    // memory read request types
    typedef logic [2:0] rd_type_t;

    localparam rd_type_t RD_TYPE_WORD = 3'd2;
    localparam rd_type_t RD_TYPE_LINE = 3'd4;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } ctrl_state_t;

endpackage

//--- hw/icache_way.sv
`timescale 1ns/1ps

module icache_way (
    input  logic               clk,
    input  logic               resetn,

    // lookup side
    input  logic               lookup_en,
    input  icache_pkg::index_t lookup_index,
    input  icache_pkg::tag_t   req_tag,

    // refill side
    input  logic               fill_en,
    input  icache_pkg::index_t fill_index,
    input  icache_pkg::tag_t   fill_tag,
    input  icache_pkg::line_t  fill_line,

    output logic               hit,
    output icache_pkg::line_t  line
);
    import icache_pkg::*;

    // storage
    tag_t                tags  [LINE_NUM];
    line_t               lines [LINE_NUM];
    logic [LINE_NUM-1:0] valid_bits;

    // values captured by the last lookup
    tag_t  tag_q;
    logic  valid_q;
    line_t line_q;

    // valid bits and the captured valid flag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (fill_en) begin
                valid_bits[fill_index] <= 1'b1;
            end
            if (lookup_en) begin
                valid_q <= valid_bits[lookup_index];
            end
        end
    end

    // tag and line arrays in block RAM style
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_index]  <= fill_tag;
            lines[fill_index] <= fill_line;
        end
        if (lookup_en) begin
            tag_q  <= tags[lookup_index];
            line_q <= lines[lookup_index];
        end
    end

    // compare against the tag of the request in flight
    assign hit  = valid_q && (tag_q == req_tag);
    assign line = line_q;

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                 clk,
    input  logic                 resetn,

    // pipeline request
    input  logic                 valid,
    input  icache_pkg::tag_t     tag,
    input  icache_pkg::index_t   index,
    input  icache_pkg::offset_t  offset,
    input  logic                 uncached,
    output logic                 addr_ok,
    output logic                 data_ok,
    output icache_pkg::word_t    rdata_l,
    output icache_pkg::word_t    rdata_h,

    // memory read port
    output logic                 rd_req,
    output icache_pkg::rd_type_t rd_type,
    output icache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  icache_pkg::word_t    ret_data,

    // ways
    input  logic                 way0_hit,
    input  logic                 way1_hit,
    input  icache_pkg::line_t    way0_line,
    input  icache_pkg::line_t    way1_line,
    output logic                 lookup_en,
    output icache_pkg::index_t   lookup_index,
    output icache_pkg::tag_t     req_tag,
    output logic                 way0_fill_en,
    output logic                 way1_fill_en,
    output icache_pkg::index_t   fill_index,
    output icache_pkg::tag_t     fill_tag,
    output icache_pkg::line_t    fill_line
);
    import icache_pkg::*;

    ctrl_state_t state;

    // request in flight
    tag_t      tag_q;
    index_t    index_q;
    offset_t   offset_q;
    logic      uncached_q;
    word_idx_t word_pos;
    word_idx_t next_pos;

    logic      accept;
    logic      cached_hit;
    logic      last_beat;
    logic      fill_go;
    logic      repl_ptr;

    // refill buffer
    word_idx_t beat_cnt;
    line_t     refill_buf;
    line_t     refill_line;
    line_t     res_line;

    function automatic word_t pick_word(line_t l, word_idx_t pos);
        return l[pos*$bits(word_t) +: $bits(word_t)];
    endfunction

    assign cached_hit = (way0_hit || way1_hit) && !uncached_q;
    assign last_beat  = ret_valid && ret_last;

    // new request only when idle or right behind a cached hit
    assign addr_ok = (state == IDLE) || ((state == LOOKUP) && cached_hit);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q      <= tag;
            index_q    <= index;
            offset_q   <= offset;
            uncached_q <= uncached;
        end
    end

    assign lookup_en    = accept;
    assign lookup_index = accept ? index : index_q;
    assign req_tag      = tag_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!cached_hit) begin
                        state <= MISS;
                    end else if (!accept) begin
                        state <= IDLE;
                    end
                end
                MISS: begin
                    state <= REFILL;
                end
                REFILL: begin
                    if (last_beat) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // read request held until the memory takes it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_req <= 1'b0;
        end else if (state == MISS) begin
            rd_req <= 1'b1;
        end else if (rd_rdy) begin
            rd_req <= 1'b0;
        end
    end

    assign rd_type = uncached_q ? RD_TYPE_WORD : RD_TYPE_LINE;
    assign rd_addr = uncached_q ? {tag_q, index_q, offset_q}
                                : {tag_q, index_q, {OFFSET_WIDTH{1'b0}}};

    // beats arrive in ascending word order
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (state == MISS) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // buffer with the current beat merged in
    always_comb begin
        refill_line = refill_buf;
        refill_line[beat_cnt*$bits(word_t) +: $bits(word_t)] = ret_data;
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            refill_buf <= refill_line;
        end
    end

    // round-robin victim select
    assign fill_go = (state == REFILL) && last_beat && !uncached_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl_ptr <= 1'b0;
        end else if (fill_go) begin
            repl_ptr <= ~repl_ptr;
        end
    end

    assign way0_fill_en = fill_go && !repl_ptr;
    assign way1_fill_en = fill_go && repl_ptr;
    assign fill_index   = index_q;
    assign fill_tag     = tag_q;
    assign fill_line    = refill_line;

    // result from the hitting way or from the line being refilled
    assign res_line = (state == REFILL) ? refill_line
                    : (way0_hit ? way0_line : way1_line);

    assign word_pos = offset_q[OFFSET_WIDTH-1:2];
    assign next_pos = word_pos + 1'b1;

    assign data_ok = ((state == LOOKUP) && cached_hit) || ((state == REFILL) && last_beat);
    assign rdata_l = uncached_q ? ret_data : pick_word(res_line, word_pos);
    // wraps at the line end where the pipeline ignores it
    assign rdata_h = pick_word(res_line, next_pos);

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                 clk,
    input  logic                 resetn,

    // pipeline side
    input  logic                 valid,
    input  icache_pkg::tag_t     tag,
    input  icache_pkg::index_t   index,
    input  icache_pkg::offset_t  offset,
    input  logic                 uncached,
    output logic                 addr_ok,
    output logic                 data_ok,
    output icache_pkg::word_t    rdata_l,
    output icache_pkg::word_t    rdata_h,

    // memory side
    output logic                 rd_req,
    output icache_pkg::rd_type_t rd_type,
    output icache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  icache_pkg::word_t    ret_data
);
    import icache_pkg::*;

    logic   lookup_en;
    index_t lookup_index;
    tag_t   req_tag;
    index_t fill_index;
    tag_t   fill_tag;
    line_t  fill_line;

    logic   way0_hit;
    logic   way1_hit;
    line_t  way0_line;
    line_t  way1_line;
    logic   way0_fill_en;
    logic   way1_fill_en;

    // both ways looked up together
    icache_way u_way0 (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .req_tag      (req_tag),
        .fill_en      (way0_fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .hit          (way0_hit),
        .line         (way0_line)
    );

    icache_way u_way1 (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .req_tag      (req_tag),
        .fill_en      (way1_fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .hit          (way1_hit),
        .line         (way1_line)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .tag          (tag),
        .index        (index),
        .offset       (offset),
        .uncached     (uncached),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata_l      (rdata_l),
        .rdata_h      (rdata_h),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .way0_hit     (way0_hit),
        .way1_hit     (way1_hit),
        .way0_line    (way0_line),
        .way1_line    (way1_line),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .req_tag      (req_tag),
        .way0_fill_en (way0_fill_en),
        .way1_fill_en (way1_fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line)
    );

endmodule

//--- verif/icache_chk.sv
`timescale 1ns/1ps

module icache_chk (
    input logic                    clk,
    input logic                    resetn,
    input icache_pkg::ctrl_state_t state,
    input logic                    addr_ok,
    input logic                    data_ok,
    input logic                    rd_req,
    input logic                    rd_rdy
);
    import icache_pkg::*;

    // memory read held until taken
    rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    // no new request while a miss is in progress
    no_accept_in_miss: assert property (@(posedge clk) disable iff (!resetn)
        (state == MISS || state == REFILL) |-> !addr_ok)
        else $error("addr_ok high in MISS or REFILL");

    no_data_in_idle: assert property (@(posedge clk) disable iff (!resetn)
        (state == IDLE) |-> !data_ok)
        else $error("data_ok high in IDLE");

    rd_req_after_reset: assert property (@(posedge clk)
        !resetn |=> !rd_req)
        else $error("rd_req high right after reset");

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int CYCLES_PER_REQ = 40;
    localparam int CLK_PERIOD     = 20;

    typedef struct packed {
        addr_t addr;
        logic  unc;
        logic  hit;
        int    cyc;
    } expect_t;

    logic     clk;
    logic     resetn;
    logic     valid;
    tag_t     tag;
    index_t   index;
    offset_t  offset;
    logic     uncached;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata_l;
    word_t    rdata_h;
    logic     rd_req;
    rd_type_t rd_type;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    logic     ret_last;
    word_t    ret_data;

    // model of both tag stores and the shared round-robin pointer
    tag_t        model_tag   [2][LINE_NUM];
    logic        model_valid [2][LINE_NUM];
    logic        model_ptr;
    expect_t     exp_q [$];
    int          front_reads;
    logic        exp_addr_ok;

    int          cycle;
    int          n_issued;
    int          n_accepted;
    int          n_retired;
    int          value_errs;
    int          other_errs;
    logic [31:0] rng;

    // memory reads are taken at posedge and served at negedge
    int          n_taken;
    int          n_served;
    addr_t       taken_addr;
    int          taken_beats;
    logic        mem_busy;
    int          mem_wait;
    int          mem_left;
    addr_t       mem_addr;

    icache_top UUT (.*);

    bind icache_ctrl icache_chk u_chk (
        .clk     (clk),
        .resetn  (resetn),
        .state   (state),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory word is the word address xor a constant rotated left by 7
    function automatic word_t mem_word(input addr_t a);
        addr_t x;
        x = {a[31:2], 2'b00} ^ 32'h5a3c_96e1;
        return {x[24:0], x[31:25]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // requests and memory responses driven on the falling edge
    initial begin
        resetn    = 1'b0;
        valid     = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        uncached  = 1'b0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rng       = 32'd76;
        n_issued  = 0;
        n_served  = 0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        mem_left  = 0;
        mem_addr  = '0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        forever begin
            @(negedge clk);
            rng = xorshift32(rng);
            // hold the request until accepted, then maybe present the next one
            if (n_accepted == n_issued) begin
                valid = 1'b0;
                if (n_issued < NUM_REQ && rng[2:0] != 3'd0) begin
                    rng      = xorshift32(rng);
                    valid    = 1'b1;
                    tag      = {18'h2b5a3, rng[1:0]};
                    index    = {5'b10110, rng[4:2]};
                    offset   = rng[8:5];
                    uncached = (rng[11:9] == 3'd0);
                    n_issued = n_issued + 1;
                end
            end
            rng       = xorshift32(rng);
            rd_rdy    = 1'b0;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            if (!mem_busy && n_served != n_taken) begin
                mem_busy = 1'b1;
                mem_addr = {taken_addr[31:2], 2'b00};
                mem_left = taken_beats;
                mem_wait = int'(rng[14:12]) + 1;
                n_served = n_served + 1;
            end
            if (mem_busy) begin
                if (mem_wait > 0) begin
                    mem_wait = mem_wait - 1;
                end else if (rng[16:15] != 2'b00) begin
                    ret_valid = 1'b1;
                    ret_data  = mem_word(mem_addr);
                    ret_last  = (mem_left == 1);
                    mem_addr  = mem_addr + 32'd4;
                    mem_left  = mem_left - 1;
                    mem_busy  = (mem_left != 0);
                end
            end else begin
                rd_rdy = (rng[18:17] != 2'b00);
            end
        end
    end

    task automatic record_request();
        expect_t e;
        logic    h0;
        logic    h1;
        h0     = model_valid[0][index] && (model_tag[0][index] == tag);
        h1     = model_valid[1][index] && (model_tag[1][index] == tag);
        e.addr = {tag, index, offset};
        e.unc  = uncached;
        e.hit  = (h0 || h1) && !uncached;
        e.cyc  = cycle;
        exp_q.push_back(e);
        // a cached miss refills the way under the pointer
        if (!uncached && !h0 && !h1) begin
            model_tag[model_ptr][index]   = tag;
            model_valid[model_ptr][index] = 1'b1;
            model_ptr = ~model_ptr;
        end
    endtask

    task automatic check_mem_read();
        rd_type_t want_type;
        addr_t    want_addr;
        assert (exp_q.size() > 0 && !exp_q[0].hit) else begin
            $display("memory read issued with no missing request pending");
            other_errs++;
        end
        if (exp_q.size() > 0 && !exp_q[0].hit) begin
            want_type = exp_q[0].unc ? RD_TYPE_WORD : RD_TYPE_LINE;
            want_addr = exp_q[0].unc ? exp_q[0].addr : {exp_q[0].addr[31:4], 4'h0};
            assert (rd_type == want_type) else begin
                $display("ERR rd_type: expected %h, got %h", want_type, rd_type);
                value_errs++;
            end
            assert (rd_addr == want_addr) else begin
                $display("ERR rd_addr: expected %h, got %h", want_addr, rd_addr);
                value_errs++;
            end
            front_reads++;
        end
    endtask

    task automatic retire_front();
        expect_t e;
        e = exp_q.pop_front();
        if (!e.hit) begin
            assert (front_reads == 1) else begin
                $display("miss at %h saw %0d memory reads instead of one",
                         e.addr, front_reads);
                other_errs++;
            end
        end
        assert (rdata_l == mem_word(e.addr)) else begin
            $display("ERR rdata_l at %h: expected %h, got %h",
                     e.addr, mem_word(e.addr), rdata_l);
            value_errs++;
        end
        // next word only within the line
        if (!e.unc && e.addr[3:2] != 2'b11) begin
            assert (rdata_h == mem_word(e.addr + 32'd4)) else begin
                $display("ERR rdata_h at %h: expected %h, got %h",
                         e.addr, mem_word(e.addr + 32'd4), rdata_h);
                value_errs++;
            end
        end
        front_reads = 0;
        n_retired++;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < LINE_NUM; s++) begin
                    model_valid[w][s] = 1'b0;
                end
            end
            model_ptr   = 1'b0;
            exp_q.delete();
            front_reads = 0;
            cycle       = 0;
            n_accepted  = 0;
            n_retired   = 0;
            value_errs  = 0;
            other_errs  = 0;
            n_taken     = 0;
            taken_addr  = '0;
            taken_beats = 0;
        end else begin
            cycle = cycle + 1;
            // idle with nothing pending, or in lookup behind a predicted hit
            exp_addr_ok = (exp_q.size() == 0) || exp_q[0].hit;
            assert (addr_ok == exp_addr_ok) else begin
                $display("ERR addr_ok: expected %h, got %h", exp_addr_ok, addr_ok);
                value_errs++;
            end
            // a predicted hit must answer in the cycle after acceptance
            if (exp_q.size() > 0 && exp_q[0].hit && cycle == exp_q[0].cyc + 1) begin
                assert (data_ok) else begin
                    $display("hit expected at %h but data_ok stayed low", exp_q[0].addr);
                    other_errs++;
                    exp_q.delete(0);
                    front_reads = 0;
                    n_retired++;
                end
            end
            if (data_ok) begin
                assert (exp_q.size() > 0) else begin
                    $display("data_ok with no request pending");
                    other_errs++;
                end
                if (exp_q.size() > 0) begin
                    retire_front();
                end
            end
            if (ret_valid && ret_last) begin
                assert (data_ok) else begin
                    $display("last memory beat came without data_ok");
                    other_errs++;
                end
            end
            if (rd_req && rd_rdy) begin
                check_mem_read();
                taken_addr  = rd_addr;
                taken_beats = (rd_type == RD_TYPE_LINE) ? 4 : 1;
                n_taken     = n_taken + 1;
            end
            if (valid && addr_ok) begin
                record_request();
                n_accepted = n_accepted + 1;
            end
        end
    end

    initial begin
        #(NUM_REQ * CYCLES_PER_REQ * CLK_PERIOD);
        $display("watchdog timeout with %0d of %0d requests retired", n_retired, NUM_REQ);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        wait (resetn);
        wait (n_retired == NUM_REQ);
        repeat (5) @(posedge clk);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_ctrl.sv
hw/icache_top.sv
verif/icache_chk.sv
verif/icache_tb.sv

//--- Makefile
TOP := icache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f $(wildcard hw/*.sv verif/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
